// File: src/dac_cfg_pkg.sv
package dac_cfg_pkg;

	////////////////////////////////////////
	// sample and channel layout
	////////////////////////////////////////

	localparam int w_data = 16;		// dac sample width
	localparam int n_chan = 8;		// channels on the board
	localparam int n_half = 4;		// channels per converter half
	localparam int w_chan = 3;		// channel number width

	////////////////////////////////////////
	// instruction queue
	////////////////////////////////////////

	localparam int fifo_depth = 16;	// queued write instructions
	localparam int w_fifo_ptr = 4;	// log2 of fifo_depth

	////////////////////////////////////////
	// serial frame
	////////////////////////////////////////

	localparam int w_frame = 24;		// bits per frame, msb first
	localparam int w_bit_cnt = 5;		// counts 0 .. w_frame-1
	localparam int w_cmd = 4;			// command field width

	// write input register and update the channel output
	localparam logic [w_cmd-1:0] cmd_write = 4'b0011;

endpackage

// File: src/dac_instr_pkg.sv
package dac_instr_pkg;

	import dac_cfg_pkg::*;

	// one queued write instruction
	typedef struct packed {
		logic [w_chan-1:0] chan;		// absolute channel 0..7
		logic [w_data-1:0] data;		// sample to write
	} dac_instr_t;

	// one pair slot from the scheduler, lower and upper half side by side
	typedef struct packed {
		logic [w_data-1:0] lower_data;
		logic [w_data-1:0] upper_data;
		logic [n_half-1:0] lower_valid;	// one-hot lane in the lower half
		logic [n_half-1:0] upper_valid;	// one-hot lane in the upper half
	} chan_pair_t;

	// field view of a frame
	typedef struct packed {
		logic [w_cmd-1:0] cmd;
		logic rsvd;							// always 0 on the wire
		logic [w_chan-1:0] chan;
		logic [w_data-1:0] data;
	} dac_frame_fields_t;

	// same 24 bits seen as a shift word or as fields
	typedef union packed {
		logic [w_frame-1:0] raw;
		dac_frame_fields_t fields;
	} dac_frame_u;

	// lane index of a one-hot half valid
	function automatic logic [w_chan-1:0] oh_to_lane(input logic [n_half-1:0] oh);
		logic [w_chan-1:0] lane;
		lane = '0;
		for (int i = 0; i < n_half; i++) begin
			if (oh[i])
				lane = lane | w_chan'(i);
		end
		return lane;
	endfunction

endpackage

// File: src/instr_fifo.sv
`timescale 1ns/1ps

module instr_fifo
	import dac_cfg_pkg::*, dac_instr_pkg::*;
(
	input logic clk_in,
	input logic rst_n,
	input dac_instr_t din,
	input logic wr_en,
	input logic rd_en,			// consume the head in dout
	output dac_instr_t dout,	// registered head entry
	output logic valid,			// dout holds an entry
	output logic overflow		// sticky until reset
);

	dac_instr_t mem [fifo_depth];
	logic [w_fifo_ptr-1:0] wr_ptr;		// wraps at fifo_depth
	logic [w_fifo_ptr-1:0] rd_ptr;
	logic [w_fifo_ptr:0] count;			// entries in mem, not counting dout

	logic full;
	logic wr_ok;
	logic load;

	assign full = (count == (w_fifo_ptr + 1)'(fifo_depth));
	assign wr_ok = wr_en && !full;
	// refill the head when it is empty or being taken
	assign load = (count != '0) && (!valid || rd_en);

	////////////////////////////////////////
	// pointers and flags
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (load)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, load})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;		// none or both
			endcase
			if (load)
				valid <= 1'b1;
			else if (rd_en)
				valid <= 1'b0;		// drained
			if (wr_en && full)
				overflow <= 1'b1;	// entry lost
		end
	end

	// storage and head register
	always_ff @(posedge clk_in) begin
		if (wr_ok)
			mem[wr_ptr] <= din;
		if (load)
			dout <= mem[rd_ptr];
	end

endmodule

// File: src/dac_pair_scheduler.sv
`timescale 1ns/1ps

module dac_pair_scheduler
	import dac_cfg_pkg::*, dac_instr_pkg::*;
(
	input logic clk_in,
	input logic rst_n,
	input logic [n_chan*w_data-1:0] samples,	// channel 0 in the low bits
	input logic [n_chan-1:0] update_mask,		// one bit per channel to write
	input logic update_strobe,						// single cycle start pulse
	output chan_pair_t pair,						// one slot every second cycle
	output logic busy								// still walking the pairs
);

	////////////////////////////////////////
	// captured update
	////////////////////////////////////////

	logic [n_chan-1:0][w_data-1:0] cap_samples;	// sample set held for the walk
	logic [n_chan-1:0] cap_mask;
	logic [n_half-1:0] pend;		// pairs not issued yet
	logic phase;						// 0 = issue slot, 1 = spacing slot

	logic [n_half-1:0] strobe_pairs;	// pairs touched by the incoming mask
	logic [n_half-1:0] low_oh;			// lowest pending pair, one-hot
	logic [n_half-1:0] pend_rest;		// pending pairs after this one
	logic [w_chan-1:0] lane;			// lower channel of the current pair
	logic [w_chan-1:0] upper_lane;	// its partner in the upper half
	logic issue;

	// pair k covers channels k and k+4
	assign strobe_pairs = update_mask[n_half-1:0] | update_mask[n_chan-1:n_half];

	assign low_oh = pend & (~pend + n_half'(1));	// isolate lowest set bit
	assign pend_rest = pend & ~low_oh;
	assign lane = oh_to_lane(low_oh);
	assign upper_lane = lane + w_chan'(n_half);
	assign issue = busy && !phase;

	////////////////////////////////////////
	// slot walk
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			busy <= 1'b0;
			phase <= 1'b0;
			pend <= '0;
			cap_mask <= '0;
		end else if (!busy) begin
			// empty masks never start a walk
			if (update_strobe && |strobe_pairs) begin
				busy <= 1'b1;
				phase <= 1'b0;
				pend <= strobe_pairs;
				cap_mask <= update_mask;
			end
		end else if (!phase) begin
			pend <= pend_rest;		// this pair goes out now
			phase <= 1'b1;
			if (pend_rest == '0)
				busy <= 1'b0;			// last issued pair
		end else begin
			phase <= 1'b0;			// spacing slot over
		end
	end

	// strobes while busy are dropped, samples included
	always_ff @(posedge clk_in) begin
		if (!busy && update_strobe)
			cap_samples <= samples;
	end

	////////////////////////////////////////
	// pair output
	////////////////////////////////////////

	always_comb begin
		pair.lower_data = cap_samples[lane];
		pair.upper_data = cap_samples[upper_lane];
		pair.lower_valid = issue ? (cap_mask[n_half-1:0] & low_oh) : '0;
		pair.upper_valid = issue ? (cap_mask[n_chan-1:n_half] & low_oh) : '0;
	end

endmodule

// File: src/dac_instr_queue.sv
`timescale 1ns/1ps

module dac_instr_queue
	import dac_cfg_pkg::*, dac_instr_pkg::*;
(
	input logic clk_in,
	input logic rst_n,
	input chan_pair_t pair,			// from the pair scheduler
	input logic rd_ack,				// writer took the head entry
	output dac_instr_t instr,		// head of the queue
	output logic instr_valid,
	output logic overflow			// sticky, a write hit a full fifo
);

	////////////////////////////////////////
	// instruction forming
	////////////////////////////////////////

	logic lower_present;
	logic upper_present;
	dac_instr_t lower_instr;
	dac_instr_t upper_instr;

	// upper half waits one cycle behind the lower half
	dac_instr_t upper_hold;
	logic upper_pend;

	dac_instr_t fifo_din;
	logic fifo_wr;

	assign lower_present = |pair.lower_valid;
	assign upper_present = |pair.upper_valid;

	always_comb begin
		lower_instr.chan = oh_to_lane(pair.lower_valid);
		lower_instr.data = pair.lower_data;
		// upper lanes sit above the lower half
		upper_instr.chan = oh_to_lane(pair.upper_valid) + w_chan'(n_half);
		upper_instr.data = pair.upper_data;
	end

	////////////////////////////////////////
	// upper delay
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n)
			upper_pend <= 1'b0;
		else
			upper_pend <= upper_present;	// write slot in the next cycle
	end

	always_ff @(posedge clk_in) begin
		if (upper_present)
			upper_hold <= upper_instr;
	end

	////////////////////////////////////////
	// fifo write mux
	////////////////////////////////////////

	// pairs are two cycles apart so both sources never collide
	assign fifo_din = lower_present ? lower_instr : upper_hold;
	assign fifo_wr = lower_present | upper_pend;

	instr_fifo instr_fifo_inst (
		.clk_in		(clk_in),
		.rst_n		(rst_n),
		.din			(fifo_din),
		.wr_en		(fifo_wr),
		.rd_en		(rd_ack),
		.dout			(instr),
		.valid		(instr_valid),
		.overflow	(overflow)
	);

endmodule

// File: src/dac_serial_writer.sv
`timescale 1ns/1ps

module dac_serial_writer
	import dac_cfg_pkg::*, dac_instr_pkg::*;
(
	input logic clk_in,
	input logic rst_n,
	input dac_instr_t instr,		// head of the instruction queue
	input logic instr_valid,
	output logic rd_ack,			// one cycle, head taken
	output logic sync_n,			// low for the whole frame
	output logic sclk,				// half the system clock, idles high
	output logic sdo				// changes on rising sclk
);

	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_gap
	} wr_state_t;

	wr_state_t state;
	logic [w_bit_cnt-1:0] bit_cnt;	// bits already on the wire
	dac_frame_u frame;				// remaining bits, msb next
	dac_frame_u frame_d;			// frame built from the head entry
	logic last_bit;

	////////////////////////////////////////
	// frame build
	////////////////////////////////////////

	always_comb begin
		frame_d.fields.cmd = cmd_write;
		frame_d.fields.rsvd = 1'b0;
		frame_d.fields.chan = instr.chan;
		frame_d.fields.data = instr.data;
	end

	assign rd_ack = (state == st_idle) && instr_valid;
	assign last_bit = (bit_cnt == w_bit_cnt'(w_frame - 1));

	////////////////////////////////////////
	// shift fsm
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			state <= st_idle;
			bit_cnt <= '0;
			sync_n <= 1'b1;
			sclk <= 1'b1;
			sdo <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (instr_valid) begin
						state <= st_shift;
						bit_cnt <= '0;
						sync_n <= 1'b0;		// frame starts next cycle
						sdo <= frame_d.raw[w_frame-1];
					end
				end
				st_shift: begin
					sclk <= ~sclk;
					// only act on the rising half
					if (!sclk) begin
						if (last_bit) begin
							state <= st_gap;
							sync_n <= 1'b1;
							sdo <= 1'b0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							sdo <= frame.raw[w_frame-2];	// next bit out
						end
					end
				end
				st_gap: begin
					state <= st_idle;		// one idle cycle between frames
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// shift register, msb leaves first
	always_ff @(posedge clk_in) begin
		if (rd_ack)
			frame <= frame_d;
		else if (state == st_shift && !sclk && !last_bit)
			frame.raw <= {frame.raw[w_frame-2:0], 1'b0};
	end

endmodule

// File: src/dac_write_top.sv
`timescale 1ns/1ps

module dac_write_top
	import dac_cfg_pkg::*, dac_instr_pkg::*;
(
	input logic clk_in,
	input logic rst_n,
	input logic [n_chan*w_data-1:0] samples,	// eight packed samples
	input logic [n_chan-1:0] update_mask,
	input logic update_strobe,
	output logic busy,
	output logic overflow,
	output logic sync_n,
	output logic sclk,
	output logic sdo
);

	////////////////////////////////////////
	// stage links
	////////////////////////////////////////

	chan_pair_t pair;			// scheduler to queue
	dac_instr_t instr;			// queue head to writer
	logic instr_valid;
	logic rd_ack;

	// input side, update split into channel pairs
	dac_pair_scheduler dac_pair_scheduler_inst (
		.clk_in			(clk_in),
		.rst_n			(rst_n),
		.samples			(samples),
		.update_mask		(update_mask),
		.update_strobe	(update_strobe),
		.pair				(pair),
		.busy				(busy)
	);

	// pairs turned into ordered write instructions
	dac_instr_queue dac_instr_queue_inst (
		.clk_in		(clk_in),
		.rst_n		(rst_n),
		.pair			(pair),
		.rd_ack		(rd_ack),
		.instr		(instr),
		.instr_valid	(instr_valid),
		.overflow	(overflow)
	);

	// one frame per instruction on the serial pins
	dac_serial_writer dac_serial_writer_inst (
		.clk_in		(clk_in),
		.rst_n		(rst_n),
		.instr		(instr),
		.instr_valid	(instr_valid),
		.rd_ack		(rd_ack),
		.sync_n		(sync_n),
		.sclk			(sclk),
		.sdo			(sdo)
	);

endmodule

// File: bench/dac_write_tb.sv
`timescale 1ns/1ps

module dac_write_tb
	import dac_cfg_pkg::*;
();

	localparam int wait_limit = 4000;	// cycles before a wait gives up
	localparam int quiet_cycles = 80;	// longer than one frame plus gap

	logic clk_in;
	logic rst_n;
	logic [n_chan*w_data-1:0] samples;
	logic [n_chan-1:0] update_mask;
	logic update_strobe;
	logic busy;
	logic overflow;
	logic sync_n;
	logic sclk;
	logic sdo;

	integer seed = 50618;
	int errors = 0;
	logic [w_frame-1:0] exp_frames[$];	// expected frame order
	logic [w_frame-1:0] rx_frames[$];	// frames seen on the wire

	always #2 clk_in = ~clk_in;	// 4 ns period

	dac_write_top dac_write_top_inst (
		.clk_in			(clk_in),
		.rst_n			(rst_n),
		.samples		(samples),
		.update_mask	(update_mask),
		.update_strobe	(update_strobe),
		.busy			(busy),
		.overflow		(overflow),
		.sync_n			(sync_n),
		.sclk			(sclk),
		.sdo			(sdo)
	);

	////////////////////////////////////////
	// frame monitor
	////////////////////////////////////////

	logic [w_frame-1:0] shift_word;
	int bit_count;
	bit in_frame = 1'b0;

	always @(negedge sync_n) begin
		in_frame = 1'b1;	// frame opens
		bit_count = 0;
		shift_word = '0;
	end

	// bit is stable on falling sclk
	always @(negedge sclk) begin
		if (!sync_n) begin
			shift_word = {shift_word[w_frame-2:0], sdo};
			bit_count++;
		end
	end

	always @(posedge sync_n) begin
		if (in_frame) begin
			if (bit_count != w_frame) begin
				errors++;
				$display("frame at %0t ns ended after %0d bits instead of %0d",
					$time, bit_count, w_frame);
			end else
				rx_frames.push_back(shift_word);
			in_frame = 1'b0;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error @ %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// cmd, reserved zero, channel, sample
	function automatic logic [w_frame-1:0] frame_of(input int ch, input logic [w_data-1:0] d);
		return {cmd_write, 1'b0, w_chan'(ch), d};
	endfunction

	task automatic random_samples(output logic [n_chan*w_data-1:0] s);
		for (int i = 0; i < n_chan; i++)
			s[i*w_data +: w_data] = $random(seed);
	endtask

	// pair k gives channel k then channel k+4
	task automatic add_expected(input logic [n_chan*w_data-1:0] s, input logic [n_chan-1:0] m);
		for (int k = 0; k < n_half; k++) begin
			if (m[k])
				exp_frames.push_back(frame_of(k, s[k*w_data +: w_data]));
			if (m[k+n_half])
				exp_frames.push_back(frame_of(k + n_half, s[(k+n_half)*w_data +: w_data]));
		end
	endtask

	// called on a falling edge, leaves on the next one
	task automatic drive_update(input logic [n_chan*w_data-1:0] s, input logic [n_chan-1:0] m);
		samples = s;
		update_mask = m;
		update_strobe = 1'b1;
		@(negedge clk_in);
		update_strobe = 1'b0;
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy && n < wait_limit) begin
			@(negedge clk_in);
			n++;
		end
		if (busy) begin
			errors++;
			$display("timed out waiting for busy to fall");
		end
	endtask

	task automatic wait_frames(input int count);
		int n;
		n = 0;
		while (rx_frames.size() < count && n < wait_limit) begin
			@(negedge clk_in);
			n++;
		end
		if (rx_frames.size() < count) begin
			errors++;
			$display("timed out with %0d of %0d frames received", rx_frames.size(), count);
		end
	endtask

	// serial side idle long enough that the queue must be empty
	task automatic wait_quiet();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < quiet_cycles && n < wait_limit) begin
			@(negedge clk_in);
			n++;
			if (sync_n && !busy)
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < quiet_cycles) begin
			errors++;
			$display("timed out waiting for the serial link to go idle");
		end
	endtask

	task automatic check_frames();
		check_value("frame count", rx_frames.size(), exp_frames.size());
		for (int i = 0; i < rx_frames.size() && i < exp_frames.size(); i++)
			check_value($sformatf("frame %0d", i), rx_frames[i], exp_frames[i]);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		check_value("sync_n after reset", sync_n, 1);
		check_value("sclk after reset", sclk, 1);
		check_value("sdo after reset", sdo, 0);
		check_value("busy after reset", busy, 0);
		check_value("overflow after reset", overflow, 0);
		repeat (100) @(negedge clk_in);	// nothing may come out
		check_value("frames without update", rx_frames.size(), 0);
	endtask

	task automatic run_update(input logic [n_chan-1:0] m);
		logic [n_chan*w_data-1:0] s;
		exp_frames.delete();
		rx_frames.delete();
		random_samples(s);
		add_expected(s, m);
		drive_update(s, m);
		wait_not_busy();
		wait_frames(exp_frames.size());
		wait_quiet();
		check_frames();
		check_value("overflow", overflow, 0);
	endtask

	task automatic test_full_update();
		run_update(8'hff);
	endtask

	task automatic test_sparse_masks();
		run_update(8'h0f);		// lower half only
		run_update(8'hf0);		// upper half only
		run_update(8'h96);		// scattered
		run_update(8'h21);		// ch0 then ch5, pair 0 upper empty
	endtask

	task automatic test_strobe_while_busy();
		logic [n_chan*w_data-1:0] sa;
		logic [n_chan*w_data-1:0] sb;
		exp_frames.delete();
		rx_frames.delete();
		random_samples(sa);
		random_samples(sb);
		add_expected(sa, 8'hff);	// second update must vanish
		drive_update(sa, 8'hff);
		check_value("busy before second strobe", busy, 1);
		drive_update(sb, 8'h3c);
		wait_not_busy();
		wait_frames(exp_frames.size());
		wait_quiet();
		check_frames();
		check_value("overflow", overflow, 0);
	endtask

	task automatic test_overflow();
		logic [n_chan*w_data-1:0] s;
		int pos;
		exp_frames.delete();
		rx_frames.delete();
		for (int u = 0; u < 3; u++) begin
			random_samples(s);
			add_expected(s, 8'hff);
			wait_not_busy();
			drive_update(s, 8'hff);
		end
		wait_not_busy();
		wait_quiet();
		check_value("overflow after 24 writes", overflow, 1);
		check_value("frames kept", rx_frames.size() >= fifo_depth, 1);
		check_value("some frames dropped", rx_frames.size() < exp_frames.size(), 1);
		// received frames keep the expected order with gaps
		pos = 0;
		for (int i = 0; i < rx_frames.size(); i++) begin
			while (pos < exp_frames.size() && exp_frames[pos] !== rx_frames[i])
				pos++;
			check_value($sformatf("frame %0d in expected order", i), pos < exp_frames.size(), 1);
			pos++;
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		clk_in = 1'b0;
		rst_n = 1'b0;
		samples = '0;
		update_mask = '0;
		update_strobe = 1'b0;
		repeat (5) @(posedge clk_in);
		@(negedge clk_in);
		rst_n = 1'b1;

		test_reset_state();
		test_full_update();
		test_sparse_masks();
		test_strobe_while_busy();
		test_overflow();	// last, overflow stays set

		$display("run complete, %0d errors", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: src.f
src/dac_cfg_pkg.sv
src/dac_instr_pkg.sv
src/instr_fifo.sv
src/dac_pair_scheduler.sv
src/dac_instr_queue.sv
src/dac_serial_writer.sv
src/dac_write_top.sv
bench/dac_write_tb.sv
